// ==== common/cpu_settings.svh ====
//####################################################################
// ISA-fixed widths and reset addresses, shared by every CPU file
// changing these breaks the instruction format in cpu_pkg
//####################################################################
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// word and register file geometry
`define CPU_DATA_W      16
`define CPU_REG_N       16
`define CPU_REG_IDX_W   4

// address space
`define CPU_ADDR_W      16
`define CPU_PC_RESET    16'h1000
`define CPU_DATA_BASE   16'h1000
`define CPU_DATA_OFS_W  12

`endif

// ==== common/cpu_pkg.sv ====
//####################################################################
// types for the 16-bit CPU; opcodes 110 and 111 are not legal
//####################################################################
`default_nettype none

package cpu_pkg;
  `include "cpu_settings.svh"

  typedef enum logic [2:0] {
    op_arith   = 3'b000,
    op_cmp_mul = 3'b001,
    op_load    = 3'b010,
    op_store   = 3'b011,
    op_beq     = 3'b100,
    op_jump    = 3'b101
  } opcode_e;

  typedef enum logic [2:0] {
    st_fetch,
    st_decode,
    st_exec,
    st_mem,
    st_retire
  } state_e;

  // r-type and i-type views of bits 12..0
  typedef struct packed {
    logic [`CPU_REG_IDX_W-1:0] rs;
    logic [`CPU_REG_IDX_W-1:0] rt;
    logic [`CPU_REG_IDX_W-1:0] rd;
    logic                      func;
  } r_fields_t;

  typedef struct packed {
    logic [`CPU_REG_IDX_W-1:0] rs;
    logic [`CPU_REG_IDX_W-1:0] rt;
    logic signed [4:0]         imm;
  } i_fields_t;

  typedef union packed {
    r_fields_t   r;
    i_fields_t   i;
    logic [12:0] target;
  } instr_body_t;

  typedef struct packed {
    opcode_e     opcode;
    instr_body_t f;
  } instr_t;

  typedef struct packed {
    logic signed [`CPU_DATA_W-1:0] rs_val;
    logic signed [`CPU_DATA_W-1:0] rt_val;
  } operand_t;

  typedef struct packed {
    logic                   rd;
    logic                   wr;
    logic [`CPU_ADDR_W-1:0] addr;
    logic [`CPU_DATA_W-1:0] wdata;
  } data_req_t;

endpackage

`default_nettype wire

// ==== verilog/reg_file.sv ====
//####################################################################
// 16 x 16 registers, async read, one write port, cleared on reset
//####################################################################
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module reg_file (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`CPU_REG_IDX_W-1:0] rd_a_idx,
  input  logic [`CPU_REG_IDX_W-1:0] rd_b_idx,
  input  logic                      wr_en,
  input  logic [`CPU_REG_IDX_W-1:0] wr_idx,
  input  logic [`CPU_DATA_W-1:0]    wr_data,
  output logic [`CPU_DATA_W-1:0]    rd_a_data,
  output logic [`CPU_DATA_W-1:0]    rd_b_data
);

  logic [`CPU_DATA_W-1:0] regs [`CPU_REG_N];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `CPU_REG_N; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // read ports see a write only after the clock edge
  assign rd_a_data = regs[rd_a_idx];
  assign rd_b_data = regs[rd_b_idx];

  a_wr_idx_known: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> !$isunknown(wr_idx))
    else $error("write with unknown register index");

endmodule

`default_nettype wire

// ==== core/cpu_control.sv ====
//####################################################################
// fetch/decode/exec/mem/retire FSM; addresses held until valid
// illegal opcodes retire as no-ops and trip an assertion
//####################################################################
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module cpu_control
  import cpu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   instr_valid,
  input  logic [`CPU_DATA_W-1:0] instr_data,
  input  logic                   data_valid,
  input  operand_t               operands,
  output logic                   instr_req,
  output logic [`CPU_ADDR_W-1:0] instr_addr,
  output data_req_t              data_req,
  output instr_t                 instr,
  output logic                   exec_en,
  output logic                   load_en,
  output logic                   io_stall
);

  state_e                 state;
  state_e                 next_state;
  logic                   boot;
  logic                   outstanding;
  logic [`CPU_ADDR_W-1:0] pc;
  logic [`CPU_ADDR_W-1:0] next_pc;
  logic [`CPU_DATA_W-1:0] imm_ext;
  logic [`CPU_DATA_W-1:0] addr_sum;
  logic [`CPU_DATA_W-1:0] addr_sum_sh;
  logic [`CPU_ADDR_W-1:0] data_addr_next;
  logic                   branch_taken;
  logic                   is_mem;
  logic                   data_rd;
  logic                   data_wr;
  logic [`CPU_ADDR_W-1:0] data_addr;
  logic [`CPU_DATA_W-1:0] data_wdata;

  //####################################################################
  // decode helpers
  //####################################################################
  assign imm_ext      = {{(`CPU_DATA_W-5){instr.f.i.imm[4]}}, instr.f.i.imm};
  assign branch_taken = (operands.rs_val == operands.rt_val);
  assign is_mem       = (instr.opcode == op_load) || (instr.opcode == op_store);

  // data address: low 12 bits of (rs + imm) << 1, rebased
  assign addr_sum       = operands.rs_val + imm_ext;
  assign addr_sum_sh    = addr_sum << 1;
  assign data_addr_next = {{(`CPU_ADDR_W-`CPU_DATA_OFS_W){1'b0}},
                           addr_sum_sh[`CPU_DATA_OFS_W-1:0]} + `CPU_DATA_BASE;

  always_comb begin
    next_pc = pc + 16'd2;
    case (instr.opcode)
      op_beq: begin
        if (branch_taken) begin
          next_pc = pc + 16'd2 + (imm_ext << 1);
        end
      end
      op_jump: next_pc = {{(`CPU_ADDR_W-13){1'b0}}, instr.f.target};
      default: ;
    endcase
  end

  //####################################################################
  // FSM
  //####################################################################
  always_comb begin
    next_state = state;
    case (state)
      st_fetch:  if (instr_valid) next_state = st_decode;
      st_decode: next_state = st_exec;
      st_exec:   next_state = is_mem ? st_mem : st_retire;
      st_mem:    if (data_valid) next_state = st_retire;
      st_retire: next_state = st_fetch;
      default:   next_state = st_fetch;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_fetch;
      io_stall <= 1'b1;
    end else begin
      state    <= next_state;
      // low only while retiring
      io_stall <= (next_state != st_retire);
    end
  end

  // first fetch right after reset, later ones right after retire
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      boot      <= 1'b1;
      instr_req <= 1'b0;
    end else begin
      boot      <= 1'b0;
      instr_req <= boot || (state == st_retire);
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_fetch && instr_valid) begin
      instr <= instr_t'(instr_data);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= `CPU_PC_RESET;
    end else if (state == st_exec) begin
      pc <= next_pc;
    end
  end
  assign instr_addr = pc;

  //####################################################################
  // data port
  //####################################################################
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_rd <= 1'b0;
      data_wr <= 1'b0;
    end else begin
      data_rd <= (state == st_exec) && (instr.opcode == op_load);
      data_wr <= (state == st_exec) && (instr.opcode == op_store);
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_exec && is_mem) begin
      data_addr  <= data_addr_next;
      data_wdata <= operands.rt_val;
    end
  end

  assign data_req = '{rd: data_rd, wr: data_wr, addr: data_addr, wdata: data_wdata};

  assign exec_en = (state == st_exec);
  assign load_en = (state == st_mem) && data_valid && (instr.opcode == op_load);

  // one request in flight across both ports
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= 1'b0;
    end else if (instr_req || data_rd || data_wr) begin
      outstanding <= 1'b1;
    end else if (instr_valid || data_valid) begin
      outstanding <= 1'b0;
    end
  end

  //####################################################################
  // checks
  //####################################################################
  a_legal_exec: assert property (@(posedge clk) disable iff (!rst_n)
    (state == st_exec) |->
      (instr.opcode inside {op_arith, op_cmp_mul, op_load, op_store, op_beq, op_jump}))
    else $error("illegal opcode %b reached exec", instr.opcode);

  a_one_port: assert property (@(posedge clk) disable iff (!rst_n)
    !(instr_req && (data_rd || data_wr)))
    else $error("instruction and data strobes high together");

  a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_req || data_rd || data_wr) |-> !outstanding)
    else $error("new request while one is outstanding");

endmodule

`default_nettype wire

// ==== core/cpu_datapath.sv ====
//####################################################################
// ALU and writeback; operands come straight off the register file
//####################################################################
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module cpu_datapath
  import cpu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  instr_t                 instr,
  input  logic                   exec_en,
  input  logic                   load_en,
  input  logic [`CPU_DATA_W-1:0] data_rdata,
  output operand_t               operands
);

  logic signed [`CPU_DATA_W-1:0]   rs_val;
  logic signed [`CPU_DATA_W-1:0]   rt_val;
  logic signed [2*`CPU_DATA_W-1:0] product;
  logic [`CPU_DATA_W-1:0]          alu_result;
  logic                            is_alu;
  logic                            wr_en;
  logic [`CPU_REG_IDX_W-1:0]       wr_idx;
  logic [`CPU_DATA_W-1:0]          wr_data;

  reg_file u_reg_file (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_a_idx  (instr.f.r.rs),
    .rd_b_idx  (instr.f.r.rt),
    .wr_en     (wr_en),
    .wr_idx    (wr_idx),
    .wr_data   (wr_data),
    .rd_a_data (rs_val),
    .rd_b_data (rt_val)
  );

  assign operands = '{rs_val: rs_val, rt_val: rt_val};

  //####################################################################
  // ALU
  //####################################################################
  // signed product, only the low word is kept
  assign product = rs_val * rt_val;

  always_comb begin
    alu_result = rs_val + rt_val;
    case ({instr.opcode, instr.f.r.func})
      {op_arith, 1'b1}:   alu_result = rs_val - rt_val;
      {op_cmp_mul, 1'b0}: alu_result = (rs_val < rt_val) ? 16'd1 : 16'd0;
      {op_cmp_mul, 1'b1}: alu_result = product[`CPU_DATA_W-1:0];
      default:            alu_result = rs_val + rt_val;
    endcase
  end

  //####################################################################
  // writeback select
  //####################################################################
  assign is_alu  = (instr.opcode == op_arith) || (instr.opcode == op_cmp_mul);
  // load result goes to rt, ALU result to rd
  assign wr_en   = (exec_en && is_alu) || load_en;
  assign wr_idx  = load_en ? instr.f.r.rt : instr.f.r.rd;
  assign wr_data = load_en ? data_rdata : alu_result;

endmodule

`default_nettype wire

// ==== core/cpu_top.sv ====
//####################################################################
// one request outstanding at a time over both ports
// io_stall low for one cycle marks each retired instruction
//####################################################################
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module cpu_top
  import cpu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  // instruction port
  output logic                   instr_req,
  output logic [`CPU_ADDR_W-1:0] instr_addr,
  input  logic                   instr_valid,
  input  logic [`CPU_DATA_W-1:0] instr_data,
  // data port
  output data_req_t              data_req,
  input  logic                   data_valid,
  input  logic [`CPU_DATA_W-1:0] data_rdata,
  // status
  output logic                   io_stall
);

  instr_t   instr;
  logic     exec_en;
  logic     load_en;
  operand_t operands;

  cpu_control u_control (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr_data  (instr_data),
    .data_valid  (data_valid),
    .operands    (operands),
    .instr_req   (instr_req),
    .instr_addr  (instr_addr),
    .data_req    (data_req),
    .instr       (instr),
    .exec_en     (exec_en),
    .load_en     (load_en),
    .io_stall    (io_stall)
  );

  cpu_datapath u_datapath (
    .clk        (clk),
    .rst_n      (rst_n),
    .instr      (instr),
    .exec_en    (exec_en),
    .load_en    (load_en),
    .data_rdata (data_rdata),
    .operands   (operands)
  );

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
//####################################################################
// free-running testbench clock, 8 ns period, starts low
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk
);

  // half period of 4 ns
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== tests/tb_cpu.sv ====
//####################################################################
// random legal program checked against a model of the ISA
// program addresses alias into the 256-word window by bits 8..1
//####################################################################
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module tb_cpu
  import cpu_pkg::*;
();

  localparam int NUM_INSTR      = 300;
  localparam int TIMEOUT_CYCLES = NUM_INSTR * 12 + 1000;

  logic               clk;
  logic               rst_n;
  logic               instr_req;
  logic [15:0]        instr_addr;
  logic               instr_valid;
  logic [15:0]        instr_data;
  data_req_t          data_req;
  logic               data_valid;
  logic [15:0]        data_rdata;
  logic               io_stall;

  logic [15:0]        prog [256];
  logic [15:0]        data_mem [2048];
  logic [15:0]        model_mem [2048];
  logic signed [15:0] model_regs [16];
  logic [15:0]        model_pc;
  logic [31:0]        rand_state;
  int                 mismatch_count;
  int                 other_count;
  int                 stall_lows;
  logic               pending;

  tb_clock u_clock (
    .clk (clk)
  );

  cpu_top u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_req   (instr_req),
    .instr_addr  (instr_addr),
    .instr_valid (instr_valid),
    .instr_data  (instr_data),
    .data_req    (data_req),
    .data_valid  (data_valid),
    .data_rdata  (data_rdata),
    .io_stall    (io_stall)
  );

  //####################################################################
  // stimulus helpers
  //####################################################################
  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // fields from the upper LCG bits, low bits repeat too quickly
  function automatic logic [15:0] gen_instr();
    logic [31:0] r;
    logic [31:0] s;
    logic [15:0] w;
    r = next_rand();
    s = next_rand();
    w = {3'((s >> 16) % 6), r[28:16]};
    case (w[15:13])
      // small branch offsets, -4..7 words
      3'd4: w[4:0] = 5'(s[23:20] % 12) - 5'd4;
      // jump target inside 0x1000..0x11fe
      3'd5: w[12:0] = {1'b1, 3'b000, s[31:24], 1'b0};
      default: ;
    endcase
    return w;
  endfunction

  function automatic logic [15:0] model_data_addr(input logic [15:0] base,
                                                  input logic [4:0]  imm);
    logic [15:0] sum;
    sum = base + {{11{imm[4]}}, imm};
    return `CPU_DATA_BASE + {4'h0, sum[10:0], 1'b0};
  endfunction

  // one clock: sample at the falling edge, drop the valid pulses
  task automatic wait_cycle();
    @(negedge clk);
    instr_valid = 1'b0;
    data_valid  = 1'b0;
    if (!io_stall) begin
      stall_lows++;
    end
    assert (!(instr_req && (data_req.rd || data_req.wr))) else begin
      other_count++;
      $display("instruction and data strobes high in the same cycle at %0t", $time);
    end
    assert (!(pending && (instr_req || data_req.rd || data_req.wr))) else begin
      other_count++;
      $display("new request issued while one was outstanding at %0t", $time);
    end
  endtask

  task automatic answer_after_delay(input logic is_data, input logic [15:0] value);
    logic [31:0] r;
    int          wait_n;
    r      = next_rand();
    wait_n = 1 + int'(r[17:16]);
    repeat (wait_n) wait_cycle();
    pending = 1'b0;
    if (is_data) begin
      data_valid = 1'b1;
      data_rdata = value;
    end else begin
      instr_valid = 1'b1;
      instr_data  = value;
    end
  endtask

  task automatic await_fetch(input int retired);
    while (instr_req !== 1'b1) begin
      assert (!(data_req.rd || data_req.wr)) else begin
        other_count++;
        $display("data strobe while waiting for a fetch at %0t", $time);
      end
      wait_cycle();
    end
    assert (stall_lows == retired) else begin
      other_count++;
      $display("io_stall went low %0d times over %0d instructions", stall_lows, retired);
    end
    assert (instr_addr === model_pc) else begin
      mismatch_count++;
      $display("MISMATCH instr_addr: got %h expected %h", instr_addr, model_pc);
    end
  endtask

  task automatic check_data_request(input logic is_store, input logic [15:0] addr,
                                    input logic [15:0] wdata);
    while (!(data_req.rd || data_req.wr || instr_req)) begin
      wait_cycle();
    end
    assert (data_req.wr === is_store && data_req.rd === !is_store) else begin
      mismatch_count++;
      $display("MISMATCH data_req.wr: got %h expected %h", data_req.wr, is_store);
    end
    assert (data_req.addr === addr) else begin
      mismatch_count++;
      $display("MISMATCH data_req.addr: got %h expected %h", data_req.addr, addr);
    end
    if (is_store) begin
      assert (data_req.wdata === wdata) else begin
        mismatch_count++;
        $display("MISMATCH data_req.wdata: got %h expected %h", data_req.wdata, wdata);
      end
    end
    pending = 1'b1;
    if (data_req.wr) begin
      data_mem[data_req.addr[11:1]] = data_req.wdata;
    end
    answer_after_delay(1'b1, data_mem[data_req.addr[11:1]]);
  endtask

  //####################################################################
  // reference model, one instruction per call
  //####################################################################
  task automatic step_model();
    logic [15:0]        word;
    logic [3:0]         rs;
    logic [3:0]         rt;
    logic [3:0]         rd;
    logic signed [15:0] a;
    logic signed [15:0] b;
    logic signed [31:0] prod;
    logic [15:0]        addr;
    logic [15:0]        next_pc;
    word    = prog[model_pc[8:1]];
    rs      = word[12:9];
    rt      = word[8:5];
    rd      = word[4:1];
    a       = model_regs[rs];
    b       = model_regs[rt];
    prod    = a * b;
    next_pc = model_pc + 16'd2;
    case (word[15:13])
      3'd0: model_regs[rd] = word[0] ? a - b : a + b;
      3'd1: model_regs[rd] = word[0] ? prod[15:0] : ((a < b) ? 16'd1 : 16'd0);
      3'd2, 3'd3: begin
        addr = model_data_addr(a, word[4:0]);
        check_data_request(word[13], addr, b);
        if (word[13]) begin
          model_mem[addr[11:1]] = b;
        end else begin
          model_regs[rt] = model_mem[addr[11:1]];
        end
      end
      3'd4: begin
        if (a == b) begin
          next_pc = model_pc + 16'd2 + 16'(2 * $signed(word[4:0]));
        end
      end
      3'd5: next_pc = {3'b000, word[12:0]};
      default: ;
    endcase
    model_pc = next_pc;
  endtask

  task automatic check_reset_outputs();
    assert (io_stall === 1'b1) else begin
      mismatch_count++;
      $display("MISMATCH io_stall: got %h expected 1", io_stall);
    end
    assert (instr_req === 1'b0 && data_req.rd === 1'b0 && data_req.wr === 1'b0) else begin
      other_count++;
      $display("request strobe high during reset at %0t", $time);
    end
  endtask

  //####################################################################
  // main sequence
  //####################################################################
  initial begin
    logic [31:0] fill;
    rand_state     = 32'h4e33_c490;
    rst_n          = 1'b0;
    instr_valid    = 1'b0;
    instr_data     = '0;
    data_valid     = 1'b0;
    data_rdata     = '0;
    mismatch_count = 0;
    other_count    = 0;
    stall_lows     = 0;
    pending        = 1'b0;
    model_pc       = `CPU_PC_RESET;
    for (int i = 0; i < 16; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      prog[i] = gen_instr();
    end
    for (int i = 0; i < 2048; i++) begin
      fill         = next_rand();
      data_mem[i]  = fill[31:16];
      model_mem[i] = fill[31:16];
    end

    repeat (2) begin
      wait_cycle();
      check_reset_outputs();
    end
    rst_n = 1'b1;

    // first cycle out of reset, fetch of the reset address
    wait_cycle();
    assert (io_stall === 1'b1 && !data_req.rd && !data_req.wr) else begin
      other_count++;
      $display("io_stall low or data strobe high right after reset");
    end
    assert (instr_addr === `CPU_PC_RESET) else begin
      mismatch_count++;
      $display("MISMATCH instr_addr: got %h expected %h", instr_addr, `CPU_PC_RESET);
    end

    for (int n = 0; n < NUM_INSTR; n++) begin
      await_fetch(n);
      pending = 1'b1;
      answer_after_delay(1'b0, prog[instr_addr[8:1]]);
      step_model();
    end
    await_fetch(NUM_INSTR);

    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: %0d instructions not retired within %0d cycles",
             NUM_INSTR, TIMEOUT_CYCLES);
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+common
common/cpu_pkg.sv
verilog/reg_file.sv
core/cpu_control.sv
core/cpu_datapath.sv
core/cpu_top.sv
tests/tb_clock.sv
tests/tb_cpu.sv

// ==== Makefile ====
# Verilator build and run for the 16-bit CPU testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu
OBJ_DIR   ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation passed

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) common/cpu_settings.svh
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
